// ==== dv/pipeline_ref_model.svh ====
// Reference model for the ALU pipeline testbench
// Register mirror, RV32I result rules and the queue of expected commits

`ifndef PIPELINE_REF_MODEL_SVH
`define PIPELINE_REF_MODEL_SVH

// Expected commit record
typedef struct packed {
    logic          wr_en;
    logic [4:0]    idx;
    logic [31:0]   data;
    logic [31:0]   npc;
    error_status_e error;
} exp_rec_t;

localparam logic [31:0] WFI_WORD = 32'h1050_0073;

logic [31:0] mirror [32];
logic [31:0] model_pc;
exp_rec_t    exp_q [$];

// RV32I op picked by funct3, alt selects sub or sra
function automatic logic [31:0] rv32i_op(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// Predict the commit of one accepted word and advance the mirror
function automatic exp_rec_t predict(input logic [31:0] w);
    exp_rec_t    r;
    logic [31:0] a;
    logic [31:0] imm;
    logic        legal;
    logic        writes;
    a      = mirror[w[19:15]];
    imm    = {{20{w[31]}}, w[31:20]};
    legal  = 1'b1;
    writes = 1'b1;
    r.idx  = w[11:7];
    r.data = 32'd0;
    case (w[6:0])
        7'b0110011: begin
            // Alternate funct7 only for sub and sra
            legal  = (w[31:25] == 7'h00) ||
                     (w[31:25] == 7'h20 && (w[14:12] == 3'd0 || w[14:12] == 3'd5));
            r.data = rv32i_op(w[14:12], w[30], a, mirror[w[24:20]]);
        end
        7'b0010011: begin
            if (w[14:12] == 3'd1)
                legal = (w[31:25] == 7'h00);
            if (w[14:12] == 3'd5)
                legal = (w[31:25] == 7'h00) || (w[31:25] == 7'h20);
            r.data = rv32i_op(w[14:12], (w[14:12] == 3'd5) && w[30], a, imm);
        end
        7'b0110111: r.data = {w[31:12], 12'h000};
        7'b1110011: begin
            writes = 1'b0;
            legal  = (w == WFI_WORD);
        end
        default: begin
            writes = 1'b0;
            legal  = 1'b0;
        end
    endcase
    r.error = !legal ? ILLEGAL_INST : (w[6:0] == 7'b1110011) ? HALTED_ON_WFI : NO_ERROR;
    r.wr_en = legal && writes && (r.idx != 5'd0);
    if (r.wr_en)
        mirror[r.idx] = r.data;
    model_pc = model_pc + 32'd4;
    r.npc    = model_pc;
    return r;
endfunction

// Back to the reset state of the core
task automatic model_reset();
    for (int i = 0; i < 32; i++)
        mirror[i] = 32'd0;
    model_pc = `START_PC;
    exp_q.delete();
endtask

`endif

// ==== dv/pipeline_tb.sv ====
// Testbench for the integer ALU pipeline
// Random RV32I ALU traffic under random back-pressure, checked by assertions
// against a reference model of the commit stream

`timescale 1ns/1ps
`include "pipeline_cfg.svh"

module pipeline_tb;
    import pipeline_pkg::*;

    `include "pipeline_ref_model.svh"

    localparam int          TIMEOUT_CYCLES = 20000;
    // lw x1, 0(x0), a load the core no longer supports
    localparam logic [31:0] LOAD_WORD      = 32'h0000_2083;

    logic          clock        = 1'b0;
    logic          rst          = 1'b1;
    logic          inst_valid   = 1'b0;
    logic [31:0]   inst         = 32'd0;
    logic          commit_ready = 1'b0;
    logic          inst_ready;
    logic          commit_valid;
    logic          commit_wr_en;
    reg_idx_t      commit_wr_idx;
    logic [31:0]   commit_wr_data;
    logic [31:0]   commit_npc;
    error_status_e commit_error;
    logic [31:0]   completed_count;

    exp_rec_t      head;
    logic          head_valid;
    logic [31:0]   commit_total;
    logic          halted_seen;
    logic          out_fire;
    int            cycle_count = 0;
    string         test_name   = "reset";

    pipeline u_pipeline (
        .clock           (clock),
        .rst             (rst),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .commit_ready    (commit_ready),
        .inst_ready      (inst_ready),
        .commit_valid    (commit_valid),
        .commit_wr_en    (commit_wr_en),
        .commit_wr_idx   (commit_wr_idx),
        .commit_wr_data  (commit_wr_data),
        .commit_npc      (commit_npc),
        .commit_error    (commit_error),
        .completed_count (completed_count)
    );

    always #50 clock = ~clock;

    // Retire side stalls about one cycle in four
    always @(posedge clock)
        commit_ready <= ($urandom % 4) != 0;

    assign out_fire = commit_valid && commit_ready;

    ////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////

    task automatic print_failure(input string what);
        $display("TESTBENCH FAILED");
        $display("%s", what);
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] expected,
                                   input logic [31:0] actual);
        print_failure($sformatf("Mismatch %s %s expected %0h actual %0h",
                                test_name, field, expected, actual));
    endtask

    ////////////////////////////////////////////////////////////
    // Expected queue upkeep
    ////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (rst) begin
            model_reset();
            head_valid   <= 1'b0;
            commit_total <= 32'd0;
            halted_seen  <= 1'b0;
        end else begin
            // Pop before push, the same edge can do both
            if (out_fire) begin
                if (exp_q.size() != 0)
                    void'(exp_q.pop_front());
                commit_total <= commit_total + 32'd1;
            end
            if (inst_valid && inst_ready) begin
                exp_q.push_back(predict(inst));
                if (exp_q[$].error != NO_ERROR)
                    halted_seen <= 1'b1;
            end
            head_valid <= (exp_q.size() != 0);
            if (exp_q.size() != 0)
                head <= exp_q[0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clock) disable iff (rst) out_fire |-> head_valid)
        else begin
            print_failure("A commit arrived with no instruction outstanding");
            $fatal(1);
        end

    assert property (@(posedge clock) disable iff (rst)
        (out_fire && head_valid) |-> (commit_error == head.error))
        else begin
            report_mismatch("error", 32'($sampled(head.error)), 32'($sampled(commit_error)));
            $fatal(1);
        end

    assert property (@(posedge clock) disable iff (rst)
        (out_fire && head_valid) |-> (commit_wr_en == head.wr_en))
        else begin
            report_mismatch("wr_en", 32'($sampled(head.wr_en)), 32'($sampled(commit_wr_en)));
            $fatal(1);
        end

    assert property (@(posedge clock) disable iff (rst)
        (out_fire && head_valid) |-> (commit_npc == head.npc))
        else begin
            report_mismatch("npc", $sampled(head.npc), $sampled(commit_npc));
            $fatal(1);
        end

    // Index and data only matter for a real write
    assert property (@(posedge clock) disable iff (rst)
        (out_fire && head_valid && head.wr_en) |-> (commit_wr_idx == head.idx))
        else begin
            report_mismatch("wr_idx", 32'($sampled(head.idx)), 32'($sampled(commit_wr_idx)));
            $fatal(1);
        end

    assert property (@(posedge clock) disable iff (rst)
        (out_fire && head_valid && head.wr_en) |-> (commit_wr_data == head.data))
        else begin
            report_mismatch("wr_data", $sampled(head.data), $sampled(commit_wr_data));
            $fatal(1);
        end

    assert property (@(posedge clock) disable iff (rst) completed_count == commit_total)
        else begin
            report_mismatch("completed_count", $sampled(commit_total),
                            $sampled(completed_count));
            $fatal(1);
        end

    assert property (@(posedge clock) disable iff (rst) halted_seen |-> !inst_ready)
        else begin
            print_failure("inst_ready went high after the pipeline halted");
            $fatal(1);
        end

    assert property (@(posedge clock) ($past(rst) && !rst) |-> inst_ready)
        else begin
            print_failure("inst_ready was low on the first cycle after reset");
            $fatal(1);
        end

    // Hard stop on a stuck pipeline
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            print_failure($sformatf("Timeout after %0d cycles with no end of test",
                                    cycle_count));
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Encoders and random ops
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] enc_r(input logic [31:0] f7, rs2, rs1, f3, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, rs1, f3, rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [31:0] imm, rd);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    // Registers drawn from lo .. lo+span-1
    function automatic logic [31:0] random_reg_op(input int lo, input int span);
        logic [31:0] f3;
        logic [31:0] f7;
        f3 = $urandom % 8;
        f7 = ((f3 == 0 || f3 == 5) && ($urandom % 2) == 1) ? 32'h20 : 32'h0;
        return enc_r(f7, lo + $urandom % span, lo + $urandom % span, f3,
                     lo + $urandom % span);
    endfunction

    // Immediate ALU op, lui now and then
    function automatic logic [31:0] random_imm_op(input int lo, input int span);
        logic [31:0] f3;
        logic [31:0] imm;
        f3  = $urandom % 8;
        imm = $urandom;
        if (($urandom % 8) == 0)
            return enc_lui(imm, lo + $urandom % span);
        if (f3 == 1)
            imm = imm % 32;
        if (f3 == 5)
            imm = (imm % 32) | (($urandom % 2) << 10);
        return enc_i(imm, lo + $urandom % span, f3, lo + $urandom % span);
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Present one word and hold it until accepted
    task automatic send(input logic [31:0] word);
        inst_valid <= 1'b1;
        inst       <= word;
        @(posedge clock);
        while (!inst_ready)
            @(posedge clock);
        inst_valid <= 1'b0;
    endtask

    task automatic drain();
        @(posedge clock);
        while (head_valid)
            @(posedge clock);
    endtask

    task automatic apply_reset();
        inst_valid <= 1'b0;
        rst        <= 1'b1;
        repeat (2) @(posedge clock);
        rst <= 1'b0;
    endtask

    // Keep offering a word while halted
    task automatic hold_after_halt(input logic [31:0] word);
        inst_valid <= 1'b1;
        inst       <= word;
        repeat (50) @(posedge clock);
        inst_valid <= 1'b0;
    endtask

    initial begin
        int unsigned seed;
        seed = $urandom(32'h6046_50dc);
        apply_reset();

        // Random values into x1..x31
        test_name = "reg_seed";
        for (int r = 1; r < 32; r++) begin
            send(enc_lui($urandom, r));
            send(enc_i($urandom, r, 0, r));
        end
        drain();

        test_name = "reg_ops";
        repeat (300) send(random_reg_op(0, 32));
        drain();

        test_name = "imm_ops";
        repeat (300) send(random_imm_op(0, 32));
        drain();

        // x1..x3 only, so almost every op depends on the one before
        test_name = "dep_chain";
        repeat (200) send(($urandom % 2) == 1 ? random_reg_op(1, 3) : random_imm_op(1, 3));
        drain();

        test_name = "zero_reg";
        repeat (20) begin
            send(enc_i($urandom, 1 + $urandom % 31, 0, 0));
            send(enc_r(0, 0, 0, 0, 1 + $urandom % 31));
        end
        drain();

        apply_reset();
        test_name = "illegal";
        repeat (20) send(random_reg_op(0, 32));
        send(LOAD_WORD);
        drain();
        hold_after_halt(random_reg_op(0, 32));

        apply_reset();
        test_name = "wfi";
        repeat (20) send(random_imm_op(0, 32));
        send(WFI_WORD);
        drain();
        hold_after_halt(random_imm_op(0, 32));

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== hw/alu_execute.sv ====
// Execute stage
// Reads operands, forwards from its own result register, runs the ALU
// and registers the result for retire

`timescale 1ns/1ps
`include "pipeline_cfg.svh"

module alu_execute (
    input  logic       clock,
    input  logic       rst,
    dec_ex_if.consumer dec,
    ex_rt_if.producer  rt,
    reg_read_if.reader rd_port
);
    import pipeline_pkg::*;

    logic             valid_q;
    ex_packet_t       packet_q;
    logic             fwd_rs1;
    logic             fwd_rs2;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_out;
    logic             take_in;

    ////////////////////////////////////////////////////////////
    // Operand read and forwarding
    ////////////////////////////////////////////////////////////

    assign rd_port.rs1_idx = dec.packet.rs1;
    assign rd_port.rs2_idx = dec.packet.rs2;

    // Held result not yet in the register file
    assign fwd_rs1 = valid_q && packet_q.wr_en && (packet_q.rd == dec.packet.rs1);
    assign fwd_rs2 = valid_q && packet_q.wr_en && (packet_q.rd == dec.packet.rs2);

    assign rs1_val = fwd_rs1 ? packet_q.result : rd_port.rs1_data;
    assign rs2_val = fwd_rs2 ? packet_q.result : rd_port.rs2_data;

    // Register or immediate for B
    assign op_b  = dec.packet.use_rs2 ? rs2_val : dec.packet.imm;
    assign shamt = op_b[4:0];

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (dec.packet.alu_func)
            ALU_ADD:  alu_out = rs1_val + op_b;
            ALU_SUB:  alu_out = rs1_val - op_b;
            ALU_SLL:  alu_out = rs1_val << shamt;
            ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, rs1_val < op_b};
            ALU_XOR:  alu_out = rs1_val ^ op_b;
            ALU_SRL:  alu_out = rs1_val >> shamt;
            ALU_SRA:  alu_out = $unsigned($signed(rs1_val) >>> shamt);
            ALU_OR:   alu_out = rs1_val | op_b;
            ALU_AND:  alu_out = rs1_val & op_b;
            default:  alu_out = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////////////

    assign dec.ready = !valid_q || rt.ready;
    assign take_in   = dec.valid && dec.ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (take_in) begin
            valid_q <= 1'b1;
        end else if (rt.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take_in) begin
            packet_q.rd     <= dec.packet.rd;
            packet_q.wr_en  <= dec.packet.wr_en;
            packet_q.result <= alu_out;
            packet_q.npc    <= dec.packet.npc;
            packet_q.error  <= dec.packet.error;
        end
    end

    assign rt.valid  = valid_q;
    assign rt.packet = packet_q;

    // Stalled output holds still
    assert property (@(posedge clock) disable iff (rst)
        (rt.valid && !rt.ready) |=> (rt.valid && $stable(rt.packet)))
        else $error("execute output changed while stalled");

endmodule

// ==== hw/inst_decode.sv ====
// Decode stage
// Accepts instruction words, classifies them and registers a decoded packet
// Tracks the PC and stops taking input after an illegal word or wfi

`timescale 1ns/1ps
`include "pipeline_cfg.svh"

module inst_decode (
    input  logic                clock,
    input  logic                rst,
    input  logic                inst_valid,
    input  pipeline_pkg::inst_t inst,
    output logic                inst_ready,
    dec_ex_if.producer          dec
);
    import pipeline_pkg::*;

    // Only SYSTEM encoding we accept
    localparam logic [31:0] WFI_WORD = 32'h1050_0073;

    logic [`XLEN-1:0] pc_q;
    logic             halted_q;
    logic             valid_q;
    dec_packet_t      packet_q;
    dec_packet_t      next_pkt;
    logic             is_illegal;
    logic             is_wfi;
    logic             has_dest;
    logic             accept;

    // funct3 to ALU op where alt selects sub or sra
    function automatic alu_func_e func_from_funct3(input logic [2:0] f3, input logic alt);
        alu_func_e f;
        case (f3)
            3'b000:  f = alt ? ALU_SUB : ALU_ADD;
            3'b001:  f = ALU_SLL;
            3'b010:  f = ALU_SLT;
            3'b011:  f = ALU_SLTU;
            3'b100:  f = ALU_XOR;
            3'b101:  f = alt ? ALU_SRA : ALU_SRL;
            3'b110:  f = ALU_OR;
            default: f = ALU_AND;
        endcase
        return f;
    endfunction

    ////////////////////////////////////////////////////////////
    // Classification
    ////////////////////////////////////////////////////////////

    always_comb begin
        is_illegal        = 1'b0;
        is_wfi            = 1'b0;
        has_dest          = 1'b0;
        next_pkt.alu_func = ALU_ADD;
        next_pkt.rs1      = inst.r_view.rs1;
        next_pkt.rs2      = inst.r_view.rs2;
        next_pkt.use_rs2  = 1'b0;
        // Sign-extended I-type immediate
        next_pkt.imm      = {{(`XLEN-12){inst.i_view.imm[11]}}, inst.i_view.imm};
        next_pkt.rd       = inst.r_view.rd;
        next_pkt.npc      = pc_q + `XLEN'd4;
        case (inst.r_view.opcode)
            OP_REG: begin
                has_dest          = 1'b1;
                next_pkt.use_rs2  = 1'b1;
                next_pkt.alu_func = func_from_funct3(inst.r_view.funct3,
                                                     inst.r_view.funct7[5]);
                // Alternate funct7 only valid for sub and sra
                if (inst.r_view.funct7 == 7'b0100000)
                    is_illegal = !(inst.r_view.funct3 inside {3'b000, 3'b101});
                else
                    is_illegal = (inst.r_view.funct7 != 7'b0000000);
            end
            OP_IMM: begin
                has_dest          = 1'b1;
                next_pkt.alu_func = func_from_funct3(inst.i_view.funct3,
                                    (inst.i_view.funct3 == 3'b101) && inst.r_view.funct7[5]);
                // Shift immediates carry funct7 in imm[11:5]
                if (inst.i_view.funct3 == 3'b001)
                    is_illegal = (inst.r_view.funct7 != 7'b0000000);
                else if (inst.i_view.funct3 == 3'b101)
                    is_illegal = !(inst.r_view.funct7 inside {7'b0000000, 7'b0100000});
            end
            OP_LUI: begin
                has_dest     = 1'b1;
                // x0 + upper immediate
                next_pkt.rs1 = reg_idx_t'(`ZERO_REG);
                next_pkt.imm = {inst.i_view.imm, inst.i_view.rs1, inst.i_view.funct3, 12'b0};
            end
            OP_SYSTEM: begin
                is_wfi     = (inst == WFI_WORD);
                is_illegal = !is_wfi;
            end
            default: is_illegal = 1'b1;
        endcase
        next_pkt.error = is_illegal ? ILLEGAL_INST :
                         is_wfi     ? HALTED_ON_WFI : NO_ERROR;
        next_pkt.wr_en = has_dest && !is_illegal && (next_pkt.rd != reg_idx_t'(`ZERO_REG));
    end

    ////////////////////////////////////////////////////////////
    // Handshake and state
    ////////////////////////////////////////////////////////////

    // Free slot or slot drains this edge
    assign inst_ready = !halted_q && (!valid_q || dec.ready);
    assign accept     = inst_valid && inst_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            valid_q  <= 1'b0;
            halted_q <= 1'b0;
            pc_q     <= `START_PC;
        end else begin
            if (accept) begin
                valid_q <= 1'b1;
                pc_q    <= next_pkt.npc;
                if (is_illegal || is_wfi)
                    halted_q <= 1'b1;
            end else if (dec.ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Payload
    always_ff @(posedge clock) begin
        if (accept)
            packet_q <= next_pkt;
    end

    assign dec.valid  = valid_q;
    assign dec.packet = packet_q;

    // Taking an illegal word or wfi closes the input from the next cycle
    assert property (@(posedge clock) disable iff (rst)
        (accept && (is_illegal || is_wfi)) |=> !inst_ready)
        else $error("decode left input open after halt");

endmodule

// ==== hw/pipeline.sv ====
// Integer ALU pipeline top level
// Decode, execute and retire joined by valid/ready links

`timescale 1ns/1ps
`include "pipeline_cfg.svh"

module pipeline (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        inst_valid,
    input  logic [31:0]                 inst,
    input  logic                        commit_ready,
    output logic                        inst_ready,
    output logic                        commit_valid,
    output logic                        commit_wr_en,
    output pipeline_pkg::reg_idx_t      commit_wr_idx,
    output logic [`XLEN-1:0]            commit_wr_data,
    output logic [`XLEN-1:0]            commit_npc,
    output pipeline_pkg::error_status_e commit_error,
    output logic [31:0]                 completed_count
);

    ////////////////////////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////////////////////////

    dec_ex_if   dec_ex ();
    ex_rt_if    ex_rt ();
    reg_read_if reg_rd ();

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////

    inst_decode u_inst_decode (
        .clock      (clock),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .dec        (dec_ex.producer)
    );

    alu_execute u_alu_execute (
        .clock   (clock),
        .rst     (rst),
        .dec     (dec_ex.consumer),
        .rt      (ex_rt.producer),
        .rd_port (reg_rd.reader)
    );

    // Commit outputs come straight from retire
    retire_regfile u_retire_regfile (
        .clock           (clock),
        .rst             (rst),
        .commit_ready    (commit_ready),
        .rt              (ex_rt.consumer),
        .rd_port         (reg_rd.file),
        .commit_valid    (commit_valid),
        .commit_wr_en    (commit_wr_en),
        .commit_wr_idx   (commit_wr_idx),
        .commit_wr_data  (commit_wr_data),
        .commit_npc      (commit_npc),
        .commit_error    (commit_error),
        .completed_count (completed_count)
    );

endmodule

// ==== hw/pipeline_cfg.svh ====
// Pipeline configuration
// Data width, register file size, zero register and reset PC

`ifndef PIPELINE_CFG_SVH
`define PIPELINE_CFG_SVH

// Datapath width
`define XLEN 32

// Architectural register count
`define REG_COUNT 32

// Hardwired zero register index
`define ZERO_REG 0

// PC of the first instruction after reset
`define START_PC 32'h0000_0000

`endif

// ==== hw/pipeline_pkg.sv ====
// Shared types for the in-order integer ALU pipeline
// Instruction layouts, opcodes, ALU functions and stage packets

`include "pipeline_cfg.svh"

package pipeline_pkg;

    // Architectural register index
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    ////////////////////////////////////////////////////////////
    // Instruction word layouts
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Same 32-bit word, read both ways by decode
    typedef union packed {
        r_type_t r_view;
        i_type_t i_view;
    } inst_t;

    // Major opcodes still supported
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_func_e;

    typedef enum logic [1:0] {
        NO_ERROR      = 2'd0,
        ILLEGAL_INST  = 2'd1,
        HALTED_ON_WFI = 2'd2
    } error_status_e;

    ////////////////////////////////////////////////////////////
    // Stage packets
    ////////////////////////////////////////////////////////////

    // Decode to execute
    typedef struct packed {
        alu_func_e        alu_func;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        logic             use_rs2;
        logic [`XLEN-1:0] imm;
        reg_idx_t         rd;
        logic             wr_en;
        logic [`XLEN-1:0] npc;
        error_status_e    error;
    } dec_packet_t;

    // Execute to retire
    typedef struct packed {
        reg_idx_t         rd;
        logic             wr_en;
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] npc;
        error_status_e    error;
    } ex_packet_t;

endpackage

// ==== hw/retire_regfile.sv ====
// Retire stage with the architectural register file
// Presents the commit record, writes results on commit and counts commits

`timescale 1ns/1ps
`include "pipeline_cfg.svh"

module retire_regfile (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        commit_ready,
    ex_rt_if.consumer                   rt,
    reg_read_if.file                    rd_port,
    output logic                        commit_valid,
    output logic                        commit_wr_en,
    output pipeline_pkg::reg_idx_t      commit_wr_idx,
    output logic [`XLEN-1:0]            commit_wr_data,
    output logic [`XLEN-1:0]            commit_npc,
    output pipeline_pkg::error_status_e commit_error,
    output logic [31:0]                 completed_count
);
    import pipeline_pkg::*;

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             commit_fire;

    ////////////////////////////////////////////////////////////
    // Commit record
    ////////////////////////////////////////////////////////////

    // Record is the execute output as is
    assign commit_valid   = rt.valid;
    assign commit_wr_en   = rt.packet.wr_en;
    assign commit_wr_idx  = rt.packet.rd;
    assign commit_wr_data = rt.packet.result;
    assign commit_npc     = rt.packet.npc;
    assign commit_error   = rt.packet.error;

    // Back-pressure straight from the commit side
    assign rt.ready    = commit_ready;
    assign commit_fire = rt.valid && commit_ready;

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////

    // x0 always reads zero
    assign rd_port.rs1_data = (rd_port.rs1_idx == reg_idx_t'(`ZERO_REG)) ?
                              '0 : regs[rd_port.rs1_idx];
    assign rd_port.rs2_data = (rd_port.rs2_idx == reg_idx_t'(`ZERO_REG)) ?
                              '0 : regs[rd_port.rs2_idx];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (commit_fire && rt.packet.wr_en) begin
            regs[rt.packet.rd] <= rt.packet.result;
        end
    end

    // Completed instruction count
    always_ff @(posedge clock) begin
        if (rst)
            completed_count <= '0;
        else if (commit_fire)
            completed_count <= completed_count + 32'd1;
    end

    // Decode never marks x0 as a destination
    assert property (@(posedge clock) disable iff (rst)
        (commit_fire && rt.packet.wr_en) |-> (rt.packet.rd != reg_idx_t'(`ZERO_REG)))
        else $error("commit wrote the zero register");

endmodule

// ==== hw/stage_if.sv ====
// Stage-to-stage interfaces
// Valid/ready links between decode, execute and retire, plus the register read port

`timescale 1ns/1ps
`include "pipeline_cfg.svh"

// Decode to execute link
interface dec_ex_if;
    import pipeline_pkg::*;

    logic        valid;
    logic        ready;
    dec_packet_t packet;

    modport producer (output valid, output packet, input ready);
    modport consumer (input valid, input packet, output ready);
endinterface

// Execute to retire link
interface ex_rt_if;
    import pipeline_pkg::*;

    logic       valid;
    logic       ready;
    ex_packet_t packet;

    modport producer (output valid, output packet, input ready);
    modport consumer (input valid, input packet, output ready);
endinterface

// Operand read port into the register file
interface reg_read_if;
    import pipeline_pkg::*;

    reg_idx_t         rs1_idx;
    reg_idx_t         rs2_idx;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;

    // Execute supplies indices
    modport reader (
        output rs1_idx,
        output rs2_idx,
        input  rs1_data,
        input  rs2_data
    );

    // Register file answers combinationally
    modport file (
        input  rs1_idx,
        input  rs2_idx,
        output rs1_data,
        output rs2_data
    );
endinterface

// ==== pipeline.f ====
+incdir+hw
+incdir+dv
hw/pipeline_pkg.sv
hw/stage_if.sv
hw/inst_decode.sv
hw/alu_execute.sv
hw/retire_regfile.sv
hw/pipeline.sv
dv/pipeline_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the pipeline testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert -sv \
    -f pipeline.f \
    --top-module pipeline_tb \
    -Mdir obj_dir

./obj_dir/Vpipeline_tb
